// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP := tbFpCompareUnit
FILELIST := sources.f
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run failed"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cmpOpPkg.sv
// compare opcodes, condition codes, flag layout and queue sizing for the compare unit
package cmpOpPkg;

  typedef enum logic [1:0] {
    opScalar = 2'd0,
    opVector = 2'd1,
    opPaired = 2'd2,
    opSearch = 2'd3
  } cmpOp;

  typedef enum logic [1:0] {
    condGe = 2'd0,
    condLt = 2'd1,
    condEq = 2'd2,
    condNe = 2'd3
  } cmpCond;

  typedef enum logic [1:0] {
    szByte  = 2'd0,
    szHalf  = 2'd1,
    szWord  = 2'd2,
    szDword = 2'd3
  } searchSize;

  localparam int flagWidth = 6;

  // compare flag positions, bit 3 stays zero
  localparam int flagUnord = 0;
  localparam int flagZero = 1;
  localparam int flagSign = 2;
  localparam int flagUnordHi = 4;
  localparam int flagNotCarry = 5;

  localparam int searchMarkWidth = 16;  // 8 markers per operand at most
  localparam int searchIndexWidth = 4;

  localparam int queueDepth = 4;
  localparam int queuePtrWidth = $clog2(queueDepth);
  localparam int queueCountWidth = $clog2(queueDepth + 1);
  localparam int creditInit = queueDepth;  // issuer starts with a full queue's worth

endpackage

// File: cmpResultPack.sv
// turns lane compare or search results into flags and a lane mask, registered for one cycle
`timescale 1ns/1ps
module cmpResultPack (
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  input  cmpOpPkg::cmpOp op,
  input  cmpOpPkg::cmpCond cond,
  input  logic afm,
  input  logic lane0Unord,
  input  logic lane0Less,
  input  logic lane0Equal,
  input  logic lane1Unord,
  input  logic lane1Less,
  input  logic lane1Equal,
  input  logic found,
  input  logic [cmpOpPkg::searchIndexWidth-1:0] index,
  output logic outValid,
  output logic [cmpOpPkg::flagWidth-1:0] flags,
  output logic [fpFormatPkg::maskWidth-1:0] laneMask,
  output fpFormatPkg::laneType lanes
);
  import fpFormatPkg::*;
  import cmpOpPkg::*;

  logic [flagWidth-1:0] flags0;
  logic [flagWidth-1:0] flags1;
  logic [flagWidth-1:0] flagsNext;
  logic cond0;
  logic cond1;
  logic [maskWidth-1:0] maskNext;
  laneType lanesNext;

  function automatic logic [flagWidth-1:0] cmpFlags(input logic unord, input logic less,
                                                     input logic equal, input logic altMode);
    logic [flagWidth-1:0] f;
    f = '0;
    f[flagNotCarry] = !(less || unord);  // carry is less or unordered
    f[flagUnordHi] = unord;
    f[flagSign] = less && !altMode;
    f[flagZero] = equal && !altMode;
    f[flagUnord] = unord;
    return f;
  endfunction

  function automatic logic condHolds(input logic [flagWidth-1:0] f, input cmpCond c);
    logic hit;
    case (c)
      condGe: hit = f[flagNotCarry];
      condLt: hit = !f[flagNotCarry];
      condEq: hit = f[flagZero];
      default: hit = !f[flagZero];
    endcase
    return hit;
  endfunction

  assign flags0 = cmpFlags(lane0Unord, lane0Less, lane0Equal, afm);
  assign flags1 = cmpFlags(lane1Unord, lane1Less, lane1Equal, afm);
  assign cond0 = condHolds(flags0, cond);
  assign cond1 = condHolds(flags1, cond);

  always_comb begin
    flagsNext = flags0;
    maskNext = '0;
    lanesNext = ptypeSingle;
    case (op)
      opVector: begin
        maskNext = {maskWidth{cond0}};
        lanesNext = ptypeDouble;
      end
      opPaired: maskNext = {{(maskWidth/2){cond1}}, {(maskWidth/2){cond0}}};
      opSearch: flagsNext = {found, index, ^index[1:0]};
      default: ;  // scalar, flags only
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
    end else begin
      outValid <= inValid;
    end
    flags <= flagsNext;
    laneMask <= maskNext;
    lanes <= lanesNext;
  end

endmodule

// File: fpClassify.sv
// splits one operand into sign, common exponent key, aligned mantissa and class for comparing
`timescale 1ns/1ps
module fpClassify (
  input  fpFormatPkg::fpFmt fmt,
  input  logic [fpFormatPkg::operandWidth-1:0] operand,
  output logic sign,
  output logic [fpFormatPkg::extExpWidth-1:0] expKey,
  output logic [fpFormatPkg::mantWidth-1:0] mant,
  output logic isZero,
  output logic isInf,
  output logic isNan
);
  import fpFormatPkg::*;

  logic [extExpWidth-1:0] rawExp;
  logic [extExpWidth-1:0] expOnes;  // all-ones exponent of this format
  logic [extExpWidth-1:0] rebias;
  logic [mantWidth-2:0] frac;       // fraction below the integer bit, left aligned
  logic intBit;
  logic expZero;
  logic expMax;

  always_comb begin
    case (fmt)
      fmtSingle: begin
        sign = operand[sglExpWidth+sglFracWidth];
        rawExp = extExpWidth'(operand[sglFracWidth +: sglExpWidth]);
        expOnes = extExpWidth'({sglExpWidth{1'b1}});
        rebias = extExpWidth'(extBias - sglBias);
        frac = {operand[sglFracWidth-1:0], {(mantWidth-1-sglFracWidth){1'b0}}};
      end
      fmtDouble: begin
        sign = operand[dblExpWidth+dblFracWidth];
        rawExp = extExpWidth'(operand[dblFracWidth +: dblExpWidth]);
        expOnes = extExpWidth'({dblExpWidth{1'b1}});
        rebias = extExpWidth'(extBias - dblBias);
        frac = {operand[dblFracWidth-1:0], {(mantWidth-1-dblFracWidth){1'b0}}};
      end
      default: begin  // extended
        sign = operand[mantWidth+extExpWidth];
        rawExp = operand[mantWidth +: extExpWidth];
        expOnes = '1;
        rebias = '0;
        frac = operand[mantWidth-2:0];
      end
    endcase
  end

  assign expZero = rawExp == '0;
  assign expMax = rawExp == expOnes;

  // hidden bit for the packed formats, stored bit for extended
  assign intBit = (fmt == fmtExt) ? operand[mantWidth-1] : ~expZero;
  assign mant = {intBit, frac};

  // specials map to the ends of the key range so keys stay comparable
  assign expKey = expZero ? '0 : (expMax ? '1 : rawExp + rebias);

  assign isZero = expZero && (mant == '0);
  assign isInf = expMax && (frac == '0);
  assign isNan = expMax && (frac != '0);

endmodule

// File: fpCompareUnit.sv
// FP compare execution unit top, issue with credits in, flags and lane mask out through a queue
`timescale 1ns/1ps
module fpCompareUnit (
  input  logic clk,
  input  logic rst,
  input  logic issueValid,
  input  cmpOpPkg::cmpOp op,
  input  fpFormatPkg::fpFmt fmt,
  input  cmpOpPkg::cmpCond cond,
  input  logic afm,
  input  cmpOpPkg::searchSize srchSize,
  input  logic [fpFormatPkg::operandWidth-1:0] a,
  input  logic [fpFormatPkg::operandWidth-1:0] b,
  input  logic resultTake,
  output logic resultValid,
  output logic [cmpOpPkg::flagWidth-1:0] flags,
  output logic [fpFormatPkg::maskWidth-1:0] laneMask,
  output fpFormatPkg::laneType lanes,
  output logic creditReturn
);
  import fpFormatPkg::*;
  import cmpOpPkg::*;

  fpFmt lane0Fmt;
  logic [operandWidth-1:0] lane1A;
  logic [operandWidth-1:0] lane1B;
  logic lane0Unord, lane0Less, lane0Equal;
  logic lane1Unord, lane1Less, lane1Equal;
  logic found;
  logic [searchIndexWidth-1:0] index;
  logic packValid;
  logic [flagWidth-1:0] packFlags;
  logic [maskWidth-1:0] packMask;
  laneType packLanes;

  // paired ops treat both halves as singles
  always_comb begin
    if (op == opPaired) begin
      lane0Fmt = fmtSingle;
    end else begin
      lane0Fmt = fmt;
    end
  end

  assign lane1A = operandWidth'(a[2*sglWidth-1:sglWidth]);  // upper single
  assign lane1B = operandWidth'(b[2*sglWidth-1:sglWidth]);

  fpMagCompare lane0Cmp (
    .fmt(lane0Fmt),
    .a(a),
    .b(b),
    .unord(lane0Unord),
    .less(lane0Less),
    .equal(lane0Equal)
  );

  fpMagCompare lane1Cmp (
    .fmt(fmtSingle),
    .a(lane1A),
    .b(lane1B),
    .unord(lane1Unord),
    .less(lane1Less),
    .equal(lane1Equal)
  );

  markerSearch search (
    .size(srchSize),
    .a(a),
    .b(b),
    .found(found),
    .index(index)
  );

  cmpResultPack pack (
    .clk(clk),
    .rst(rst),
    .inValid(issueValid),
    .op(op),
    .cond(cond),
    .afm(afm),
    .lane0Unord(lane0Unord),
    .lane0Less(lane0Less),
    .lane0Equal(lane0Equal),
    .lane1Unord(lane1Unord),
    .lane1Less(lane1Less),
    .lane1Equal(lane1Equal),
    .found(found),
    .index(index),
    .outValid(packValid),
    .flags(packFlags),
    .laneMask(packMask),
    .lanes(packLanes)
  );

  // credits held by the issuer keep this from overflowing
  resultQueue queue (
    .clk(clk),
    .rst(rst),
    .push(packValid),
    .pushFlags(packFlags),
    .pushMask(packMask),
    .pushLanes(packLanes),
    .take(resultTake),
    .resultValid(resultValid),
    .flags(flags),
    .laneMask(laneMask),
    .lanes(lanes),
    .creditReturn(creditReturn)
  );

endmodule

// File: fpFormatPkg.sv
// float formats, field widths and lane tags shared by the compare datapath and its testbench
package fpFormatPkg;

  typedef enum logic [1:0] {
    fmtSingle = 2'd0,
    fmtDouble = 2'd1,
    fmtExt    = 2'd2
  } fpFmt;

  // operand bus, extended layout is sign:exp[14:0]:mant[63:0]
  localparam int operandWidth = 80;
  localparam int mantWidth = 64;  // integer bit is explicit at the top
  localparam int extExpWidth = 15;
  localparam int extBias = 16383;

  localparam int sglExpWidth = 8;
  localparam int sglFracWidth = 23;
  localparam int sglBias = 127;
  localparam int sglWidth = 1 + sglExpWidth + sglFracWidth;

  localparam int dblExpWidth = 11;
  localparam int dblFracWidth = 52;
  localparam int dblBias = 1023;

  localparam int maskWidth = 64;

  // tag that says how the packed lane mask is split
  typedef enum logic [1:0] {
    ptypeSingle = 2'd0,  // two 32-bit lanes
    ptypeDouble = 2'd1   // one 64-bit lane
  } laneType;

endpackage

// File: fpMagCompare.sv
// IEEE ordered compare of two operands in one format, giving unordered, less-than and equal
`timescale 1ns/1ps
module fpMagCompare (
  input  fpFormatPkg::fpFmt fmt,
  input  logic [fpFormatPkg::operandWidth-1:0] a,
  input  logic [fpFormatPkg::operandWidth-1:0] b,
  output logic unord,
  output logic less,
  output logic equal
);
  import fpFormatPkg::*;

  logic aSign;
  logic bSign;
  logic [extExpWidth-1:0] aKey;
  logic [extExpWidth-1:0] bKey;
  logic [mantWidth-1:0] aMant;
  logic [mantWidth-1:0] bMant;
  logic aZero, aInf, aNan;
  logic bZero, bInf, bNan;
  logic magLess;
  logic magEq;
  logic bothZero;
  logic signedLess;

  fpClassify classA (
    .fmt(fmt),
    .operand(a),
    .sign(aSign),
    .expKey(aKey),
    .mant(aMant),
    .isZero(aZero),
    .isInf(aInf),
    .isNan(aNan)
  );

  fpClassify classB (
    .fmt(fmt),
    .operand(b),
    .sign(bSign),
    .expKey(bKey),
    .mant(bMant),
    .isZero(bZero),
    .isInf(bInf),
    .isNan(bNan)
  );

  assign magEq = (aKey == bKey) && (aMant == bMant);
  assign magLess = (aKey < bKey) || ((aKey == bKey) && (aMant < bMant));

  always_comb begin
    if (aSign != bSign) begin
      signedLess = aSign;  // negative below positive
    end else if (aSign) begin
      signedLess = !magLess && !magEq;  // both negative, larger magnitude is lower
    end else begin
      signedLess = magLess;
    end
  end

  assign bothZero = aZero && bZero;
  assign unord = aNan || bNan;
  assign less = !unord && !bothZero && signedLess;
  assign equal = !unord && (bothZero || ((aSign == bSign) && (magEq || (aInf && bInf))));

endmodule

// File: markerSearch.sv
// finds the lowest lane whose top bit is set across both operands, for the bit search opcode
`timescale 1ns/1ps
module markerSearch (
  input  cmpOpPkg::searchSize size,
  input  logic [fpFormatPkg::operandWidth-1:0] a,
  input  logic [fpFormatPkg::operandWidth-1:0] b,
  output logic found,
  output logic [cmpOpPkg::searchIndexWidth-1:0] index
);
  import cmpOpPkg::*;

  logic [searchMarkWidth/2-1:0] aMarks;
  logic [searchMarkWidth/2-1:0] bMarks;
  logic [searchMarkWidth-1:0] marks;

  // top bit of every lane in the low 64 bits, unused slots stay zero
  always_comb begin
    aMarks = '0;
    bMarks = '0;
    case (size)
      szByte: for (int i = 0; i < 8; i++) begin
        aMarks[i] = a[8*i+7];
        bMarks[i] = b[8*i+7];
      end
      szHalf: for (int i = 0; i < 4; i++) begin
        aMarks[i] = a[16*i+15];
        bMarks[i] = b[16*i+15];
      end
      szWord: for (int i = 0; i < 2; i++) begin
        aMarks[i] = a[32*i+31];
        bMarks[i] = b[32*i+31];
      end
      default: begin
        aMarks[0] = a[63];
        bMarks[0] = b[63];
      end
    endcase
  end

  assign marks = {bMarks, aMarks};  // A searched first
  assign found = |marks;

  // lowest set bit wins
  always_comb begin
    index = '0;
    for (int i = searchMarkWidth - 1; i >= 0; i--) begin
      if (marks[i]) index = searchIndexWidth'(i);
    end
  end

endmodule

// File: resultQueue.sv
// small result FIFO in front of the consumer, returns one issue credit per taken entry
`timescale 1ns/1ps
module resultQueue (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  logic [cmpOpPkg::flagWidth-1:0] pushFlags,
  input  logic [fpFormatPkg::maskWidth-1:0] pushMask,
  input  fpFormatPkg::laneType pushLanes,
  input  logic take,
  output logic resultValid,
  output logic [cmpOpPkg::flagWidth-1:0] flags,
  output logic [fpFormatPkg::maskWidth-1:0] laneMask,
  output fpFormatPkg::laneType lanes,
  output logic creditReturn
);
  import fpFormatPkg::*;
  import cmpOpPkg::*;

  logic [flagWidth-1:0] flagsMem [queueDepth];
  logic [maskWidth-1:0] maskMem [queueDepth];
  laneType lanesMem [queueDepth];
  logic [queuePtrWidth-1:0] head;
  logic [queuePtrWidth-1:0] tail;
  logic [queueCountWidth-1:0] count;
  logic popNow;

  function automatic logic [queuePtrWidth-1:0] nextPtr(input logic [queuePtrWidth-1:0] ptr);
    return (ptr == queuePtrWidth'(queueDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign resultValid = count != '0;
  assign popNow = take && resultValid;  // take on an empty queue is dropped

  // head entry is always on the outputs
  assign flags = flagsMem[head];
  assign laneMask = maskMem[head];
  assign lanes = lanesMem[head];

  always_ff @(posedge clk) begin
    if (push) begin
      flagsMem[tail] <= pushFlags;
      maskMem[tail] <= pushMask;
      lanesMem[tail] <= pushLanes;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      creditReturn <= 1'b0;
    end else begin
      if (push) tail <= nextPtr(tail);
      if (popNow) head <= nextPtr(head);
      case ({push, popNow})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;  // none or both, level unchanged
      endcase
      creditReturn <= popNow;
    end
  end

endmodule

// File: sources.f
+incdir+.
fpFormatPkg.sv
cmpOpPkg.sv
fpClassify.sv
fpMagCompare.sv
markerSearch.sv
cmpResultPack.sv
resultQueue.sv
fpCompareUnit.sv
tbFpCompareUnit.sv

// File: tbRefModel.svh
// expected-result model for the compare unit testbench, included inside the testbench module
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// sign, magnitude and class taken straight from the IEEE field layout
function automatic void refFields(input fpFmt f, input logic [79:0] v, output logic s,
                                  output logic [78:0] mag, output logic nan,
                                  output logic inf, output logic zero);
  logic expMax;
  logic fracNz;
  case (f)
    fmtSingle: begin
      s = v[31];
      mag = 79'(v[30:0]);
      expMax = &v[30:23];
      fracNz = |v[22:0];
    end
    fmtDouble: begin
      s = v[63];
      mag = 79'(v[62:0]);
      expMax = &v[62:52];
      fracNz = |v[51:0];
    end
    default: begin
      s = v[79];
      mag = v[78:0];
      expMax = &v[78:64];
      fracNz = |v[62:0];  // integer bit does not count
    end
  endcase
  nan = expMax && fracNz;
  inf = expMax && !fracNz;
  zero = mag == '0;
endfunction

// {unord, less, equal}, magnitudes of one format order as plain integers
function automatic logic [2:0] refCompare(input fpFmt f, input logic [79:0] x,
                                          input logic [79:0] y);
  logic xs, xn, xi, xz;
  logic ys, yn, yi, yz;
  logic [78:0] xm;
  logic [78:0] ym;
  logic below;
  logic unord;
  refFields(f, x, xs, xm, xn, xi, xz);
  refFields(f, y, ys, ym, yn, yi, yz);
  unord = xn || yn;
  if (xs != ys) below = xs;
  else if (xs) below = xm > ym;
  else below = xm < ym;
  return {unord,
          !unord && !(xz && yz) && below,
          !unord && ((xz && yz) || ((xs == ys) && ((xm == ym) || (xi && yi))))};
endfunction

function automatic logic [5:0] refFlags(input logic [2:0] r, input logic alt);
  logic [5:0] f;
  f = '0;
  f[flagNotCarry] = !(r[1] || r[2]);  // carry is less or unordered
  f[flagUnordHi] = r[2];
  f[flagSign] = r[1] && !alt;
  f[flagZero] = r[0] && !alt;
  f[flagUnord] = r[2];
  return f;
endfunction

function automatic logic refCond(input logic [5:0] f, input cmpCond c);
  logic hit;
  case (c)
    condGe: hit = f[flagNotCarry];
    condLt: hit = !f[flagNotCarry];
    condEq: hit = f[flagZero];
    default: hit = !f[flagZero];
  endcase
  return hit;
endfunction

// lane markers, A in slots 0..7 and B in slots 8..15, lowest set slot wins
function automatic logic [5:0] refSearch(input searchSize s, input logic [79:0] x,
                                         input logic [79:0] y);
  int w;
  logic [15:0] marks;
  logic hit;
  logic [3:0] ix;
  w = 8 << int'(s);
  marks = '0;
  for (int i = 0; i < 64 / w; i++) begin
    marks[i] = x[w * i + w - 1];
    marks[8 + i] = y[w * i + w - 1];
  end
  hit = 1'b0;
  ix = '0;
  for (int i = 0; i < 16; i++) begin
    if (marks[i] && !hit) begin
      hit = 1'b1;
      ix = 4'(i);
    end
  end
  return {hit, ix, ^ix[1:0]};
endfunction

// {flags, lane mask, lane type} for one issued op
function automatic logic [71:0] refExpected(input cmpOp o, input fpFmt f, input cmpCond c,
                                            input logic alt, input searchSize s,
                                            input logic [79:0] x, input logic [79:0] y);
  logic [5:0] fl0;
  logic [5:0] fl1;
  logic [63:0] mask;
  laneType lt;
  fl0 = refFlags(refCompare((o == opPaired) ? fmtSingle : f, x, y), alt);
  fl1 = refFlags(refCompare(fmtSingle, 80'(x[63:32]), 80'(y[63:32])), alt);
  mask = '0;
  lt = ptypeSingle;
  case (o)
    opVector: begin
      mask = {64{refCond(fl0, c)}};
      lt = ptypeDouble;
    end
    opPaired: mask = {{32{refCond(fl1, c)}}, {32{refCond(fl0, c)}}};
    opSearch: fl0 = refSearch(s, x, y);
    default: ;
  endcase
  return {fl0, mask, lt};
endfunction

`endif

// File: tbFpCompareUnit.sv
// FP compare unit testbench that issues directed and random ops under credits and checks results
`timescale 1ns/1ps
module tbFpCompareUnit;
  import fpFormatPkg::*;
  import cmpOpPkg::*;

  `include "tbRefModel.svh"

  localparam int clkPeriod = 8;
  localparam int seedInit = 52;
  localparam int numDirected = 9 * 9 * 3 * 2;
  localparam int numScalarRand = 300;
  localparam int numLaneRand = 320;
  localparam int numSearch = 160;
  localparam int totalOps = numDirected + numScalarRand + numLaneRand + numSearch + 1;

  logic clk;
  logic rst;
  logic issueValid;
  cmpOp op;
  fpFmt fmt;
  cmpCond cond;
  logic afm;
  searchSize srchSize;
  logic [operandWidth-1:0] a;
  logic [operandWidth-1:0] b;
  logic resultTake;
  logic resultValid;
  logic [flagWidth-1:0] flags;
  logic [maskWidth-1:0] laneMask;
  laneType lanes;
  logic creditReturn;

  integer stimSeed;
  integer takeSeed;
  int credits;  // issuer side
  int taken;
  logic [71:0] expQ[$];  // expected results in issue order

  fpCompareUnit fpCompareUnit_inst (
    .clk(clk),
    .rst(rst),
    .issueValid(issueValid),
    .op(op),
    .fmt(fmt),
    .cond(cond),
    .afm(afm),
    .srchSize(srchSize),
    .a(a),
    .b(b),
    .resultTake(resultTake),
    .resultValid(resultValid),
    .flags(flags),
    .laneMask(laneMask),
    .lanes(lanes),
    .creditReturn(creditReturn)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic compareValues(input logic [79:0] got, input logic [79:0] exp,
                               input string what);
    if (got !== exp) begin
      abortRun($sformatf("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                         $time, what, got, exp));
    end
  endtask

  // one clock that also counts any credit that came back
  task automatic tick();
    @(posedge clk);
    if (creditReturn) credits++;
  endtask

  task automatic idle(input int n);
    issueValid <= 1'b0;
    repeat (n) tick();
  endtask

  task automatic issueOp(input cmpOp o, input fpFmt f, input cmpCond c, input logic alt,
                         input searchSize s, input logic [79:0] x, input logic [79:0] y);
    while (credits == 0) begin
      issueValid <= 1'b0;
      tick();
    end
    op <= o;
    fmt <= f;
    cond <= c;
    afm <= alt;
    srchSize <= s;
    a <= x;
    b <= y;
    issueValid <= 1'b1;
    credits--;
    expQ.push_back(refExpected(o, f, c, alt, s, x, y));
    tick();
  endtask

  // kind 0..8 is +0 -0 +1 -1 +2 -2 +inf -inf qNaN
  function automatic logic [79:0] special(input fpFmt f, input int kind);
    logic s;
    int bias;
    int emax;
    logic [14:0] e;
    logic [62:0] frac;
    logic [79:0] v;
    bias = (f == fmtSingle) ? 127 : ((f == fmtDouble) ? 1023 : 16383);
    emax = 2 * bias + 1;
    s = (kind < 8) && (kind % 2 == 1);
    if (kind < 2) e = '0;
    else if (kind < 4) e = 15'(bias);
    else if (kind < 6) e = 15'(bias + 1);
    else e = 15'(emax);
    frac = (kind == 8) ? {1'b1, 62'd0} : '0;
    case (f)
      fmtSingle: v = 80'({s, e[7:0], frac[62:40]});
      fmtDouble: v = 80'({s, e[10:0], frac[62:11]});
      default: v = {s, e, kind >= 2, frac};
    endcase
    return v;
  endfunction

  task automatic randPair(input fpFmt f, output logic [79:0] x, output logic [79:0] y);
    logic [31:0] r;
    int signPos;
    r = $random(stimSeed);
    signPos = (f == fmtSingle) ? 31 : ((f == fmtDouble) ? 63 : 79);
    x = 80'({$random(stimSeed), $random(stimSeed), $random(stimSeed)});
    y = 80'({$random(stimSeed), $random(stimSeed), $random(stimSeed)});
    case (r[2:0])
      3'd0: y = x;
      3'd1: y = x ^ (80'(1) << signPos);  // same magnitude with the opposite sign
      3'd2: y = x ^ 80'(1);
      3'd3: y = special(f, 8);
      3'd4: begin
        x = special(f, 1);
        y = special(f, 0);
      end
      3'd5: begin
        x = x | (80'(1) << signPos);  // both negative
        y = y | (80'(1) << signPos);
      end
      default: ;
    endcase
  endtask

  // roughly one bit in eight set
  task automatic sparseWord(output logic [79:0] x);
    x = 80'({$random(stimSeed), $random(stimSeed), $random(stimSeed)});
    x = x & 80'({$random(stimSeed), $random(stimSeed), $random(stimSeed)});
    x = x & 80'({$random(stimSeed), $random(stimSeed), $random(stimSeed)});
  endtask

  initial begin : stimulus
    logic [79:0] x;
    logic [79:0] y;
    logic [79:0] xh;
    logic [79:0] yh;
    logic [31:0] r;
    int fi;
    int cycles;
    stimSeed = seedInit;
    credits = creditInit;
    rst <= 1'b1;
    issueValid <= 1'b0;
    op <= opScalar;
    fmt <= fmtSingle;
    cond <= condGe;
    afm <= 1'b0;
    srchSize <= szByte;
    a <= '0;
    b <= '0;
    tick();
    tick();
    rst <= 1'b0;
    compareValues(80'(resultValid), 80'(0), "resultValid after reset");

    for (int am = 0; am < 2; am++) begin
      for (fi = 0; fi < 3; fi++) begin
        for (int i = 0; i < 9; i++) begin
          for (int j = 0; j < 9; j++) begin
            issueOp(opScalar, fpFmt'(2'(fi)), cmpCond'(2'(i + j)), 1'(am), szByte,
                    special(fpFmt'(2'(fi)), i), special(fpFmt'(2'(fi)), j));
          end
        end
      end
    end

    for (int k = 0; k < numScalarRand; k++) begin
      r = $random(stimSeed);
      fi = int'(r % 3);
      randPair(fpFmt'(2'(fi)), x, y);
      issueOp(opScalar, fpFmt'(2'(fi)), cmpCond'(2'(k)), r[8], szByte, x, y);
      if (k % 50 == 49) idle(30);  // gap between bursts
    end

    for (int k = 0; k < numLaneRand; k++) begin
      r = $random(stimSeed);
      fi = int'(r % 3);
      if (k % 2 == 0) begin
        randPair(fpFmt'(2'(fi)), x, y);
        issueOp(opVector, fpFmt'(2'(fi)), cmpCond'(2'(k >> 1)), r[8], szByte, x, y);
      end else begin
        randPair(fmtSingle, x, y);
        randPair(fmtSingle, xh, yh);
        issueOp(opPaired, fpFmt'(2'(fi)), cmpCond'(2'(k >> 1)), r[8], szByte,
                {r[31:16], xh[31:0], x[31:0]}, {r[15:0], yh[31:0], y[31:0]});
      end
    end

    for (int k = 0; k < numSearch; k++) begin
      sparseWord(x);
      sparseWord(y);
      if (k % 8 == 0) y = '0;
      if (k % 8 < 2) x = '0;
      issueOp(opSearch, fmtDouble, condGe, 1'b0, searchSize'(2'(k)), x, y);
    end

    // latency on an idle pipeline
    issueValid <= 1'b0;
    while (expQ.size() != 0) tick();
    repeat (4) tick();
    issueOp(opScalar, fmtDouble, condEq, 1'b0, szByte, special(fmtDouble, 2),
            special(fmtDouble, 4));
    issueValid <= 1'b0;
    cycles = 0;
    while (!resultValid && cycles < 10) begin
      tick();
      cycles++;
    end
    compareValues(80'(cycles), 80'(2), "issue to resultValid latency");

    while (expQ.size() != 0) tick();
    repeat (4) tick();
    compareValues(80'(credits), 80'(creditInit), "credits after drain");
    compareValues(80'(resultValid), 80'(0), "resultValid after drain");
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin : resultChecker
    logic [71:0] expEntry;
    logic [31:0] r;
    logic creditDue;
    int holdCount;
    takeSeed = seedInit;
    taken = 0;
    creditDue = 1'b0;
    holdCount = 0;
    resultTake <= 1'b0;
    forever begin
      @(posedge clk);
      if (!rst) begin
        compareValues(80'(creditReturn), 80'(creditDue), "creditReturn after take");
        creditDue = resultTake && resultValid;
        if (creditDue) begin
          if (expQ.size() == 0) abortRun("a result appeared that was never issued");
          expEntry = expQ.pop_front();
          compareValues(80'(flags), 80'(expEntry[71:66]),
                        $sformatf("flags of result %0d", taken));
          compareValues(80'(laneMask), 80'(expEntry[65:2]),
                        $sformatf("mask of result %0d", taken));
          compareValues(80'(lanes), 80'(expEntry[1:0]),
                        $sformatf("lanes of result %0d", taken));
          taken++;
        end
        r = $random(takeSeed);
        if (holdCount != 0) begin
          holdCount--;
          resultTake <= 1'b0;
        end else if (r[5:0] == 6'd0) begin
          holdCount = 20 + int'(r[9:6]);  // long stretch with no takes
          resultTake <= 1'b0;
        end else begin
          resultTake <= r[10];
        end
      end
    end
  end

  initial begin : watchdog
    repeat (totalOps * 20 + 200) @(posedge clk);
    abortRun("timeout: the run did not finish within the allowed number of cycles");
  end

endmodule
